// ==== source/tcp_tx_consts.svh ====
`ifndef TCP_TX_CONSTS_SVH
`define TCP_TX_CONSTS_SVH

`define TCP_PROTO          8'd6

`define TCP_OPT_NOP        8'd1
`define TCP_OPT_MSS        8'd2
`define TCP_OPT_WIN        8'd3
`define TCP_OPT_SACK_PERM  8'd4
`define TCP_OPT_TS         8'd8

`define TCP_OPT_MSS_LEN       8'd4
`define TCP_OPT_WIN_LEN       8'd3
`define TCP_OPT_SACK_PERM_LEN 8'd2
`define TCP_OPT_TS_LEN        8'd10

`define MIN_HDR_LEN    20
`define MAX_OPT_WORDS  6
`define MAX_HDR_LEN    44
`define PSEUDO_WORDS   6
`define HDR_WORDS      10

`endif

// ==== source/tcp_tx_pkg.sv ====
package tcp_tx_pkg;

  typedef logic [15:0] port_t;
  typedef logic [31:0] seq_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [8:0]  tcp_flags_t;   // NS down to FIN
  typedef logic [15:0] length_t;
  typedef logic [15:0] cks_t;
  typedef logic [31:0] opt_word_t;
  typedef logic [3:0]  opt_pres_t;    // MSS, window scale, SACK-permitted, timestamp from bit 0
  typedef logic [5:0]  hdr_len_t;
  typedef logic [7:0]  tx_byte_t;

  typedef enum logic [1:0] {
    pack_idle,
    pack_scan,
    pack_hold
  } pack_state_t;

  typedef enum logic [1:0] {
    cks_idle,
    cks_sum,
    cks_fin,
    cks_hold
  } cks_state_t;

  typedef enum logic [1:0] {
    ser_idle,
    ser_ready,
    ser_hdr,
    ser_pld
  } ser_state_t;

endpackage : tcp_tx_pkg

// ==== source/tcp_opt_packer.sv ====
`timescale 1ns/100ps
`include "tcp_tx_consts.svh"

module tcp_opt_packer (
  input  logic                                        clk,
  input  logic                                        fsm_rst,
  input  logic                                        seg_rdy,
  input  tcp_tx_pkg::port_t                           src_port,
  input  tcp_tx_pkg::port_t                           dst_port,
  input  tcp_tx_pkg::seq_t                            seq_num,
  input  tcp_tx_pkg::seq_t                            ack_num,
  input  tcp_tx_pkg::tcp_flags_t                      flags,
  input  tcp_tx_pkg::cks_t                            wnd_size,
  input  tcp_tx_pkg::cks_t                            urg_ptr,
  input  tcp_tx_pkg::ip_addr_t                        src_ip,
  input  tcp_tx_pkg::ip_addr_t                        dst_ip,
  input  tcp_tx_pkg::length_t                         pld_len,
  input  tcp_tx_pkg::cks_t                            pld_cks,
  input  tcp_tx_pkg::cks_t                            mss,
  input  tcp_tx_pkg::tx_byte_t                        wnd_shift,
  input  tcp_tx_pkg::seq_t                            ts_val,
  input  tcp_tx_pkg::seq_t                            ts_ecr,
  input  tcp_tx_pkg::opt_pres_t                       opt_pres,
  input  logic                                        next_busy,
  output logic                                        seg_acc,
  output logic                                        opt_vld,
  output logic                                        busy,
  output tcp_tx_pkg::port_t                           pk_src_port,
  output tcp_tx_pkg::port_t                           pk_dst_port,
  output tcp_tx_pkg::seq_t                            pk_seq_num,
  output tcp_tx_pkg::seq_t                            pk_ack_num,
  output tcp_tx_pkg::tcp_flags_t                      pk_flags,
  output tcp_tx_pkg::cks_t                            pk_wnd_size,
  output tcp_tx_pkg::cks_t                            pk_urg_ptr,
  output tcp_tx_pkg::ip_addr_t                        pk_src_ip,
  output tcp_tx_pkg::ip_addr_t                        pk_dst_ip,
  output tcp_tx_pkg::length_t                         pk_pld_len,
  output tcp_tx_pkg::cks_t                            pk_pld_cks,
  output tcp_tx_pkg::opt_word_t [0:`MAX_OPT_WORDS-1]  opt_words,   // Word 0 goes out first
  output logic [2:0]                                  opt_cnt,
  output tcp_tx_pkg::hdr_len_t                        hdr_len
);
  import tcp_tx_pkg::*;

  pack_state_t                       state;
  opt_word_t [`MAX_OPT_WORDS-1:0]    proto;   // Top word is scanned first
  logic [`MAX_OPT_WORDS-1:0]         pres;
  logic [2:0]                        scan_cnt;

  assign busy    = (state != pack_idle);
  assign hdr_len = hdr_len_t'(`MIN_HDR_LEN) + {1'b0, opt_cnt, 2'b00};

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= pack_idle;
      seg_acc <= 1'b0;
      opt_vld <= 1'b0;
    end else begin
      seg_acc <= 1'b0;
      opt_vld <= 1'b0;
      case (state)
        pack_idle: if (seg_rdy) begin
          seg_acc <= 1'b1;
          state   <= pack_scan;
        end
        pack_scan: if (scan_cnt == 3'(`MAX_OPT_WORDS - 1)) state <= pack_hold;
        pack_hold: if (!next_busy) begin
          opt_vld <= 1'b1;
          state   <= pack_idle;
        end
        default: state <= pack_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == pack_idle && seg_rdy) begin
      pk_src_port <= src_port;
      pk_dst_port <= dst_port;
      pk_seq_num  <= seq_num;
      pk_ack_num  <= ack_num;
      pk_flags    <= flags;
      pk_wnd_size <= wnd_size;
      pk_urg_ptr  <= urg_ptr;
      pk_src_ip   <= src_ip;
      pk_dst_ip   <= dst_ip;
      pk_pld_len  <= pld_len;
      pk_pld_cks  <= pld_cks;
      // Last transmitted word on top, so packing ends with MSS at word 0
      proto <= {ts_ecr,
                ts_val,
                {`TCP_OPT_NOP, `TCP_OPT_NOP, `TCP_OPT_TS, `TCP_OPT_TS_LEN},
                {`TCP_OPT_NOP, `TCP_OPT_NOP, `TCP_OPT_SACK_PERM, `TCP_OPT_SACK_PERM_LEN},
                {`TCP_OPT_NOP, `TCP_OPT_WIN, `TCP_OPT_WIN_LEN, wnd_shift},
                {`TCP_OPT_MSS, `TCP_OPT_MSS_LEN, mss}};
      pres      <= {{3{opt_pres[3]}}, opt_pres[2], opt_pres[1], opt_pres[0]};
      opt_words <= '0;
      opt_cnt   <= 3'd0;
      scan_cnt  <= 3'd0;
    end
    if (state == pack_scan) begin
      proto    <= {proto[`MAX_OPT_WORDS-2:0], 32'h0};
      pres     <= {pres[`MAX_OPT_WORDS-2:0], 1'b0};
      scan_cnt <= scan_cnt + 3'd1;
      if (pres[`MAX_OPT_WORDS-1]) begin   // Present words push in at the front
        opt_words <= {proto[`MAX_OPT_WORDS-1], opt_words[0:`MAX_OPT_WORDS-2]};
        opt_cnt   <= opt_cnt + 3'd1;
      end
    end
  end

endmodule : tcp_opt_packer

// ==== source/tcp_cks_calc.sv ====
`timescale 1ns/100ps
`include "tcp_tx_consts.svh"

module tcp_cks_calc (
  input  logic                                        clk,
  input  logic                                        fsm_rst,
  input  logic                                        opt_vld,
  input  logic                                        next_busy,
  input  tcp_tx_pkg::port_t                           src_port,
  input  tcp_tx_pkg::port_t                           dst_port,
  input  tcp_tx_pkg::seq_t                            seq_num,
  input  tcp_tx_pkg::seq_t                            ack_num,
  input  tcp_tx_pkg::tcp_flags_t                      flags,
  input  tcp_tx_pkg::cks_t                            wnd_size,
  input  tcp_tx_pkg::cks_t                            urg_ptr,
  input  tcp_tx_pkg::ip_addr_t                        src_ip,
  input  tcp_tx_pkg::ip_addr_t                        dst_ip,
  input  tcp_tx_pkg::length_t                         pld_len,
  input  tcp_tx_pkg::cks_t                            pld_cks,
  input  tcp_tx_pkg::opt_word_t [0:`MAX_OPT_WORDS-1]  opt_words,
  input  logic [2:0]                                  opt_cnt,
  input  tcp_tx_pkg::hdr_len_t                        hdr_len,
  output logic                                        busy,
  output logic                                        cks_vld,
  output tcp_tx_pkg::cks_t                            cks,
  output tcp_tx_pkg::port_t                           ck_src_port,
  output tcp_tx_pkg::port_t                           ck_dst_port,
  output tcp_tx_pkg::seq_t                            ck_seq_num,
  output tcp_tx_pkg::seq_t                            ck_ack_num,
  output tcp_tx_pkg::tcp_flags_t                      ck_flags,
  output tcp_tx_pkg::cks_t                            ck_wnd_size,
  output tcp_tx_pkg::cks_t                            ck_urg_ptr,
  output tcp_tx_pkg::opt_word_t [0:`MAX_OPT_WORDS-1]  ck_opt_words,
  output tcp_tx_pkg::hdr_len_t                        ck_hdr_len,
  output tcp_tx_pkg::length_t                         ck_pld_len,
  output tcp_tx_pkg::length_t                         ip_len
);
  import tcp_tx_pkg::*;

  localparam int NUM_WORDS = `PSEUDO_WORDS + `HDR_WORDS + 2 * `MAX_OPT_WORDS;

  cks_state_t                state;
  ip_addr_t                  src_ip_r;
  ip_addr_t                  dst_ip_r;
  logic [2:0]                opt_cnt_r;
  logic [16:0]               acc;       // Bit 16 holds the carry of the last add
  logic [4:0]                idx;
  logic [4:0]                last_idx;
  logic [NUM_WORDS*16-1:0]   word_vec;
  cks_t                      word;

  assign busy     = (state != cks_idle);
  assign last_idx = 5'(`PSEUDO_WORDS + `HDR_WORDS - 1) + {1'b0, opt_cnt_r, 1'b0};
  assign word_vec = {src_ip_r, dst_ip_r, 8'h00, `TCP_PROTO, ip_len,
                     ck_src_port, ck_dst_port, ck_seq_num, ck_ack_num,
                     ck_hdr_len[5:2], 3'b000, ck_flags,
                     ck_wnd_size, 16'h0000, ck_urg_ptr,   // Checksum field summed as zero
                     ck_opt_words};
  assign word     = word_vec[(NUM_WORDS - 1 - idx) * 16 +: 16];

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= cks_idle;
      cks_vld <= 1'b0;
    end else begin
      cks_vld <= 1'b0;
      case (state)
        cks_idle: if (opt_vld) state <= cks_sum;
        cks_sum:  if (idx == last_idx) state <= cks_fin;
        cks_fin: begin
          cks_vld <= !next_busy;
          state   <= next_busy ? cks_hold : cks_idle;
        end
        cks_hold: if (!next_busy) begin
          cks_vld <= 1'b1;
          state   <= cks_idle;
        end
        default: state <= cks_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == cks_idle && opt_vld) begin
      ck_src_port  <= src_port;
      ck_dst_port  <= dst_port;
      ck_seq_num   <= seq_num;
      ck_ack_num   <= ack_num;
      ck_flags     <= flags;
      ck_wnd_size  <= wnd_size;
      ck_urg_ptr   <= urg_ptr;
      ck_opt_words <= opt_words;
      ck_hdr_len   <= hdr_len;
      ck_pld_len   <= pld_len;
      ip_len       <= length_t'(hdr_len) + pld_len;
      src_ip_r     <= src_ip;
      dst_ip_r     <= dst_ip;
      opt_cnt_r    <= opt_cnt;
      acc          <= {1'b0, pld_cks};
      idx          <= 5'd0;
    end
    if (state == cks_sum) begin
      acc <= {1'b0, acc[15:0]} + 17'(acc[16]) + {1'b0, word};
      idx <= idx + 5'd1;
    end
    if (state == cks_fin) cks <= ~(acc[15:0] + 16'(acc[16]));   // Last carry folded here
  end

endmodule : tcp_cks_calc

// ==== source/tcp_seg_serializer.sv ====
`timescale 1ns/100ps
`include "tcp_tx_consts.svh"

module tcp_seg_serializer (
  input  logic                                        clk,
  input  logic                                        fsm_rst,
  input  logic                                        cks_vld,
  input  tcp_tx_pkg::port_t                           src_port,
  input  tcp_tx_pkg::port_t                           dst_port,
  input  tcp_tx_pkg::seq_t                            seq_num,
  input  tcp_tx_pkg::seq_t                            ack_num,
  input  tcp_tx_pkg::tcp_flags_t                      flags,
  input  tcp_tx_pkg::cks_t                            wnd_size,
  input  tcp_tx_pkg::cks_t                            urg_ptr,
  input  tcp_tx_pkg::cks_t                            cks,
  input  tcp_tx_pkg::opt_word_t [0:`MAX_OPT_WORDS-1]  opt_words,
  input  tcp_tx_pkg::hdr_len_t                        hdr_len,
  input  tcp_tx_pkg::length_t                         ip_len,
  input  tcp_tx_pkg::length_t                         pld_len,
  input  logic                                        out_req,
  input  logic                                        out_err,
  input  tcp_tx_pkg::tx_byte_t                        pld_dat,
  output logic                                        busy,
  output logic                                        out_rdy,
  output tcp_tx_pkg::length_t                         out_len,
  output logic                                        pld_req,
  output tcp_tx_pkg::tx_byte_t                        out_dat,
  output logic                                        out_val,
  output logic                                        out_sof,
  output logic                                        out_eof
);
  import tcp_tx_pkg::*;

  ser_state_t                        state;
  logic [`MAX_HDR_LEN-1:0][7:0]      hdr;    // Top byte goes out next
  length_t                           hlen;
  length_t                           plen;
  length_t                           cnt;
  logic                              hdr_last;
  logic                              pld_last;

  assign busy     = (state != ser_idle);
  assign hdr_last = (cnt == hlen - 16'd1);
  assign pld_last = (cnt == plen - 16'd1);

  // Buffer answers a cycle late and out_dat is registered, so ask two cycles ahead
  assign pld_req = (state == ser_hdr && hdr_last && plen != 16'd0) ||
                   (state == ser_pld && !pld_last);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= ser_idle;
      out_rdy <= 1'b0;
      out_val <= 1'b0;
      out_sof <= 1'b0;
      out_eof <= 1'b0;
    end else begin
      out_val <= 1'b0;
      out_sof <= 1'b0;
      out_eof <= 1'b0;
      case (state)
        ser_idle: if (cks_vld) begin
          out_rdy <= 1'b1;
          state   <= ser_ready;
        end
        ser_ready: if (out_req) begin
          out_rdy <= 1'b0;
          state   <= ser_hdr;
        end
        ser_hdr: begin
          out_val <= 1'b1;
          out_sof <= (cnt == 16'd0);
          if (hdr_last) begin
            out_eof <= (plen == 16'd0);
            state   <= (plen == 16'd0) ? ser_idle : ser_pld;
          end
        end
        ser_pld: begin
          out_val <= 1'b1;
          if (pld_last) begin
            out_eof <= 1'b1;
            state   <= ser_idle;
          end
        end
        default: state <= ser_idle;
      endcase
      if (out_err && state != ser_idle) begin   // Abort from IPv4 side
        state   <= ser_idle;
        out_rdy <= 1'b0;
        out_val <= 1'b0;
        out_sof <= 1'b0;
        out_eof <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      ser_idle: if (cks_vld) begin
        hdr <= {src_port, dst_port, seq_num, ack_num,
                hdr_len[5:2], 3'b000, flags,
                wnd_size, cks, urg_ptr,
                opt_words};
        out_len <= ip_len;
        hlen    <= length_t'(hdr_len);
        plen    <= pld_len;
      end
      ser_ready: cnt <= 16'd0;
      ser_hdr: begin
        out_dat <= hdr[`MAX_HDR_LEN-1];
        hdr     <= {hdr[`MAX_HDR_LEN-2:0], 8'h00};
        cnt     <= hdr_last ? 16'd0 : cnt + 16'd1;
      end
      ser_pld: begin
        out_dat <= pld_dat;
        cnt     <= cnt + 16'd1;
      end
      default: cnt <= 16'd0;
    endcase
  end

endmodule : tcp_seg_serializer

// ==== source/tcp_tx_top.sv ====
`timescale 1ns/100ps
`include "tcp_tx_consts.svh"

module tcp_tx_top (
  input  logic                      clk,
  input  logic                      fsm_rst,
  input  logic                      seg_rdy,
  output logic                      seg_acc,
  input  tcp_tx_pkg::port_t         src_port,
  input  tcp_tx_pkg::port_t         dst_port,
  input  tcp_tx_pkg::seq_t          seq_num,
  input  tcp_tx_pkg::seq_t          ack_num,
  input  tcp_tx_pkg::tcp_flags_t    flags,
  input  tcp_tx_pkg::cks_t          wnd_size,
  input  tcp_tx_pkg::cks_t          urg_ptr,
  input  tcp_tx_pkg::ip_addr_t      src_ip,
  input  tcp_tx_pkg::ip_addr_t      dst_ip,
  input  tcp_tx_pkg::length_t       pld_len,
  input  tcp_tx_pkg::cks_t          pld_cks,
  input  tcp_tx_pkg::cks_t          mss,
  input  tcp_tx_pkg::tx_byte_t      wnd_shift,
  input  tcp_tx_pkg::seq_t          ts_val,
  input  tcp_tx_pkg::seq_t          ts_ecr,
  input  tcp_tx_pkg::opt_pres_t     opt_pres,
  output logic                      pld_req,
  input  tcp_tx_pkg::tx_byte_t      pld_dat,
  output logic                      out_rdy,
  output tcp_tx_pkg::length_t       out_len,
  input  logic                      out_req,
  input  logic                      out_err,
  output tcp_tx_pkg::tx_byte_t      out_dat,
  output logic                      out_val,
  output logic                      out_sof,
  output logic                      out_eof
);
  import tcp_tx_pkg::*;

  logic                              opt_vld, cks_vld;
  logic                              cks_busy, ser_busy;
  port_t                             pk_src_port, pk_dst_port, ck_src_port, ck_dst_port;
  seq_t                              pk_seq_num, pk_ack_num, ck_seq_num, ck_ack_num;
  tcp_flags_t                        pk_flags, ck_flags;
  cks_t                              pk_wnd_size, pk_urg_ptr, ck_wnd_size, ck_urg_ptr;
  ip_addr_t                          pk_src_ip, pk_dst_ip;
  length_t                           pk_pld_len, ck_pld_len, ip_len;
  cks_t                              pk_pld_cks, cks;
  opt_word_t [0:`MAX_OPT_WORDS-1]    opt_words, ck_opt_words;
  logic [2:0]                        opt_cnt;
  hdr_len_t                          hdr_len, ck_hdr_len;

  tcp_opt_packer tcp_opt_packer_inst (
    .clk, .fsm_rst, .seg_rdy, .src_port, .dst_port, .seq_num, .ack_num, .flags,
    .wnd_size, .urg_ptr, .src_ip, .dst_ip, .pld_len, .pld_cks, .mss, .wnd_shift,
    .ts_val, .ts_ecr, .opt_pres, .next_busy(cks_busy), .seg_acc, .opt_vld,
    .busy(), .pk_src_port, .pk_dst_port, .pk_seq_num, .pk_ack_num,
    .pk_flags, .pk_wnd_size, .pk_urg_ptr, .pk_src_ip, .pk_dst_ip, .pk_pld_len,
    .pk_pld_cks, .opt_words, .opt_cnt, .hdr_len
  );

  tcp_cks_calc tcp_cks_calc_inst (
    .clk, .fsm_rst, .opt_vld, .next_busy(ser_busy),
    .src_port(pk_src_port), .dst_port(pk_dst_port), .seq_num(pk_seq_num),
    .ack_num(pk_ack_num), .flags(pk_flags), .wnd_size(pk_wnd_size),
    .urg_ptr(pk_urg_ptr), .src_ip(pk_src_ip), .dst_ip(pk_dst_ip),
    .pld_len(pk_pld_len), .pld_cks(pk_pld_cks), .opt_words, .opt_cnt, .hdr_len,
    .busy(cks_busy), .cks_vld, .cks, .ck_src_port, .ck_dst_port, .ck_seq_num,
    .ck_ack_num, .ck_flags, .ck_wnd_size, .ck_urg_ptr, .ck_opt_words,
    .ck_hdr_len, .ck_pld_len, .ip_len
  );

  tcp_seg_serializer tcp_seg_serializer_inst (
    .clk, .fsm_rst, .cks_vld,
    .src_port(ck_src_port), .dst_port(ck_dst_port), .seq_num(ck_seq_num),
    .ack_num(ck_ack_num), .flags(ck_flags), .wnd_size(ck_wnd_size),
    .urg_ptr(ck_urg_ptr), .cks, .opt_words(ck_opt_words), .hdr_len(ck_hdr_len),
    .ip_len, .pld_len(ck_pld_len), .out_req, .out_err, .pld_dat,
    .busy(ser_busy), .out_rdy, .out_len, .pld_req, .out_dat, .out_val,
    .out_sof, .out_eof
  );

endmodule : tcp_tx_top

// ==== verif/tcp_tx_tb.sv ====
`timescale 1ns/100ps
`include "tcp_tx_consts.svh"

module tcp_tx_tb;
  import tcp_tx_pkg::*;

  localparam int NUM_SEGS  = 53;
  localparam int MAX_PLD   = 64;
  localparam int MAX_BYTES = `MAX_HDR_LEN + MAX_PLD;

  logic clk = 1'b0;
  logic fsm_rst, seg_rdy, seg_acc, pld_req, out_rdy, out_req, out_err;
  logic out_val, out_sof, out_eof;
  port_t src_port, dst_port;
  seq_t seq_num, ack_num, ts_val, ts_ecr;
  tcp_flags_t flags;
  cks_t wnd_size, urg_ptr, pld_cks, mss;
  ip_addr_t src_ip, dst_ip;
  length_t pld_len, out_len;
  tx_byte_t wnd_shift, pld_dat, out_dat;
  opt_pres_t opt_pres;

  // Per-segment stimulus and expected stream
  port_t s_sport[NUM_SEGS], s_dport[NUM_SEGS];
  seq_t s_seq[NUM_SEGS], s_ack[NUM_SEGS], s_tsv[NUM_SEGS], s_tse[NUM_SEGS];
  tcp_flags_t s_flags[NUM_SEGS];
  cks_t s_wnd[NUM_SEGS], s_urg[NUM_SEGS], s_mss[NUM_SEGS], s_pcks[NUM_SEGS];
  ip_addr_t s_sip[NUM_SEGS], s_dip[NUM_SEGS];
  tx_byte_t s_shift[NUM_SEGS];
  opt_pres_t s_pres[NUM_SEGS];
  length_t s_plen[NUM_SEGS];
  string s_name[NUM_SEGS];
  tx_byte_t pld_mem[NUM_SEGS][MAX_PLD];
  tx_byte_t exp_mem[NUM_SEGS][MAX_BYTES];
  int exp_len[NUM_SEGS];

  logic [15:0] lfsr = 16'd61;
  int n_sent = 0, done_cnt = 0, err_val = 0, err_prot = 0;
  int cyc = 0, req_cyc = 0, req_seg = 0, buf_seg = 0, rd_cnt = 0;
  int chk_seg = 0, idx = 0;
  logic capturing = 1'b0, req_en = 1'b1, fetch;
  tx_byte_t exp_byte;

  tcp_tx_top tcp_tx_top_inst (.*);

  always #4 clk = ~clk;

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];   // x^16 + x^14 + x^13 + x^11 + 1
      lfsr = {lfsr[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic cks_t ones_add(cks_t a, cks_t b);
    logic [16:0] s;
    s = {1'b0, a} + {1'b0, b};
    return s[15:0] + {15'd0, s[16]};
  endfunction

  function automatic cks_t payload_sum(int s);
    cks_t sum;
    sum = 16'h0000;
    for (int i = 0; i < int'(s_plen[s]); i += 2)
      sum = ones_add(sum, {pld_mem[s][i], (i + 1 < int'(s_plen[s])) ? pld_mem[s][i+1] : 8'h00});
    return sum;
  endfunction

  // Expected bytes of segment s with options packed in MSS, WS, SACK-perm, TS order
  function automatic void build_ref(int s);
    opt_word_t w[$];
    logic [159:0] fixed;
    cks_t sum;
    int hl, n;
    w = {};
    if (s_pres[s][0]) w.push_back({`TCP_OPT_MSS, `TCP_OPT_MSS_LEN, s_mss[s]});
    if (s_pres[s][1]) w.push_back({`TCP_OPT_NOP, `TCP_OPT_WIN, `TCP_OPT_WIN_LEN, s_shift[s]});
    if (s_pres[s][2])
      w.push_back({`TCP_OPT_NOP, `TCP_OPT_NOP, `TCP_OPT_SACK_PERM, `TCP_OPT_SACK_PERM_LEN});
    if (s_pres[s][3]) begin
      w.push_back({`TCP_OPT_NOP, `TCP_OPT_NOP, `TCP_OPT_TS, `TCP_OPT_TS_LEN});
      w.push_back(s_tsv[s]);
      w.push_back(s_tse[s]);
    end
    hl = `MIN_HDR_LEN + 4 * w.size();
    fixed = {s_sport[s], s_dport[s], s_seq[s], s_ack[s], 4'(hl / 4), 3'b000, s_flags[s],
             s_wnd[s], 16'h0000, s_urg[s]};
    sum = s_pcks[s];
    sum = ones_add(sum, s_sip[s][31:16]);
    sum = ones_add(sum, s_sip[s][15:0]);
    sum = ones_add(sum, s_dip[s][31:16]);
    sum = ones_add(sum, s_dip[s][15:0]);
    sum = ones_add(sum, {8'h00, `TCP_PROTO});
    sum = ones_add(sum, 16'(hl) + s_plen[s]);
    for (int i = 0; i < `HDR_WORDS; i++) sum = ones_add(sum, fixed[159-16*i -: 16]);
    foreach (w[i]) begin
      sum = ones_add(sum, w[i][31:16]);
      sum = ones_add(sum, w[i][15:0]);
    end
    fixed[31:16] = ~sum;
    n = 0;
    for (int i = 0; i < `MIN_HDR_LEN; i++) begin
      exp_mem[s][n] = fixed[159-8*i -: 8];
      n++;
    end
    foreach (w[i])
      for (int j = 0; j < 4; j++) begin
        exp_mem[s][n] = w[i][31-8*j -: 8];
        n++;
      end
    for (int i = 0; i < int'(s_plen[s]); i++) begin
      exp_mem[s][n] = pld_mem[s][i];
      n++;
    end
    exp_len[s] = n;
  endfunction

  function automatic void make_seg(int s, string name, opt_pres_t pres, int len);
    s_name[s]  = name;
    s_sport[s] = port_t'(rand_bits(16));
    s_dport[s] = port_t'(rand_bits(16));
    s_seq[s]   = rand_bits(32);
    s_ack[s]   = rand_bits(32);
    s_flags[s] = tcp_flags_t'(rand_bits(9));
    s_wnd[s]   = cks_t'(rand_bits(16));
    s_urg[s]   = cks_t'(rand_bits(16));
    s_sip[s]   = rand_bits(32);
    s_dip[s]   = rand_bits(32);
    s_mss[s]   = cks_t'(rand_bits(16));
    s_shift[s] = tx_byte_t'(rand_bits(4));
    s_tsv[s]   = rand_bits(32);
    s_tse[s]   = rand_bits(32);
    s_pres[s]  = pres;
    s_plen[s]  = 16'(len);
    for (int i = 0; i < len; i++) pld_mem[s][i] = tx_byte_t'(rand_bits(8));
    s_pcks[s] = payload_sum(s);
    build_ref(s);
  endfunction

  task automatic drive_seg(int s);
    @(posedge clk);
    #1;
    src_port = s_sport[s];
    dst_port = s_dport[s];
    seq_num = s_seq[s];
    ack_num = s_ack[s];
    flags = s_flags[s];
    wnd_size = s_wnd[s];
    urg_ptr = s_urg[s];
    src_ip = s_sip[s];
    dst_ip = s_dip[s];
    pld_len = s_plen[s];
    pld_cks = s_pcks[s];
    mss = s_mss[s];
    wnd_shift = s_shift[s];
    ts_val = s_tsv[s];
    ts_ecr = s_tse[s];
    opt_pres = s_pres[s];
    seg_rdy = 1'b1;
  endtask

  task automatic wait_acc();
    int t;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!seg_acc && t < 400);
    assert (seg_acc) else begin
      err_prot++;
      $display("seg_acc never came for segment %0d", n_sent);
    end
    n_sent++;
    #1 seg_rdy = 1'b0;
  endtask

  task automatic send_seg(string name, opt_pres_t pres, int len);
    make_seg(n_sent, name, pres, len);
    drive_seg(n_sent);
    wait_acc();
  endtask

  task automatic wait_drain();
    while (done_cnt < n_sent) @(posedge clk);
  endtask

  // Downstream requester, payload buffer model and stream checker
  always @(posedge clk) begin
    cyc++;
    if (!fsm_rst) begin
      if (out_req) begin
        assert (out_rdy) else begin
          err_prot++;
          $display("out_rdy fell before out_req was taken");
        end
        assert (out_len == 16'(exp_len[req_seg])) else begin
          err_val++;
          $display("error %s: out_len expected %0d actual %0d", s_name[req_seg],
                   exp_len[req_seg], out_len);
        end
        req_cyc = cyc;
        buf_seg = req_seg;
        req_seg++;
        rd_cnt = 0;
      end
      fetch = pld_req;
      if (out_val) begin
        if (out_sof) begin
          assert (!capturing) else begin
            err_prot++;
            $display("sof arrived inside a running frame");
          end
          assert (cyc == req_cyc + 2) else begin
            err_prot++;
            $display("stream did not start two cycles after out_req");
          end
          capturing = 1'b1;
          idx = 0;
        end
        assert (capturing) else begin
          err_prot++;
          $display("byte with out_val came without a sof");
        end
        if (capturing) begin
          exp_byte = exp_mem[chk_seg][idx];
          assert (idx < exp_len[chk_seg] && out_dat == exp_byte) else begin
            err_val++;
            $display("error %s: seg %0d byte %0d expected %02h actual %02h",
                     s_name[chk_seg], chk_seg, idx, exp_byte, out_dat);
          end
          idx++;
          if (out_eof) begin
            assert (idx == exp_len[chk_seg] && rd_cnt == int'(s_plen[chk_seg])) else begin
              err_prot++;
              $display("segment %0d ended after %0d bytes and %0d payload reads", chk_seg,
                       idx, rd_cnt);
            end
            capturing = 1'b0;
            chk_seg++;
            done_cnt++;
          end
        end
      end else begin
        assert (!capturing) else begin
          err_prot++;
          $display("stream gap inside segment %0d", chk_seg);
        end
      end
      if (out_err && capturing) begin   // Aborted frame counts as finished
        capturing = 1'b0;
        chk_seg++;
        done_cnt++;
      end
      #1;
      if (fetch) begin
        pld_dat = pld_mem[buf_seg][rd_cnt % MAX_PLD];
        rd_cnt++;
      end
      if (out_req) out_req = 1'b0;
      else if (out_rdy && req_en) out_req = 1'b1;
    end
  end

  initial begin
    repeat (NUM_SEGS * 200) @(posedge clk);
    $display("timeout: only %0d of %0d segments finished", done_cnt, n_sent);
    $display("sim failed");
    $finish;
  end

  initial begin
    fsm_rst = 1'b1;
    {seg_rdy, out_req, out_err} = '0;
    {src_port, dst_port, seq_num, ack_num, flags, wnd_size, urg_ptr} = '0;
    {src_ip, dst_ip, pld_len, pld_cks, mss, wnd_shift, ts_val, ts_ecr, opt_pres} = '0;
    pld_dat = 8'h00;
    repeat (3) @(posedge clk);
    #1 fsm_rst = 1'b0;
    assert (!seg_acc && !out_rdy && !out_val && !out_sof && !out_eof && !pld_req) else begin
      err_prot++;
      $display("control outputs were not low after reset");
    end

    send_seg("no_options", 4'b0000, 10);
    send_seg("opt_mss", 4'b0001, 12);
    send_seg("opt_wscale", 4'b0010, 7);
    send_seg("opt_sack_perm", 4'b0100, 1);
    send_seg("opt_timestamp", 4'b1000, 20);
    send_seg("opt_all", 4'b1111, 33);
    send_seg("empty_payload", 4'b1111, 0);
    for (int i = 0; i < 40; i++)
      send_seg("random", opt_pres_t'(rand_bits(4)), int'(rand_bits(7)) % (MAX_PLD + 1));
    wait_drain();

    req_en = 1'b0;   // Stall the downstream side
    for (int i = 0; i < 3; i++) send_seg("stall", opt_pres_t'(rand_bits(4)), 16 + i);
    make_seg(n_sent, "stall", 4'b0101, 9);
    drive_seg(n_sent);
    repeat (40) begin
      @(posedge clk);
      assert (!seg_acc) else begin
        err_prot++;
        $display("fourth segment was accepted while all stages were full");
      end
    end
    req_en = 1'b1;
    wait_acc();
    wait_drain();

    send_seg("abort", 4'b1011, 64);
    while (!capturing) @(posedge clk);
    repeat (5) @(posedge clk);
    #1 out_err = 1'b1;
    @(posedge clk);
    #1 out_err = 1'b0;
    send_seg("after_abort", 4'b0011, 25);
    wait_drain();
    repeat (4) @(posedge clk);

    $display("checks done: %0d value errors, %0d protocol errors", err_val, err_prot);
    if (err_val == 0 && err_prot == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule : tcp_tx_tb

// ==== sources.f ====
+incdir+source
source/tcp_tx_pkg.sv
source/tcp_opt_packer.sv
source/tcp_cks_calc.sv
source/tcp_seg_serializer.sv
source/tcp_tx_top.sv
verif/tcp_tx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= tcp_tx_tb
RTL_TOP   ?= tcp_tx_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -Isource source/tcp_tx_pkg.sv \
		source/tcp_opt_packer.sv source/tcp_cks_calc.sv source/tcp_seg_serializer.sv \
		source/tcp_tx_top.sv --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf $(BUILD_DIR)
